// File: prog_config.svh
`ifndef PROG_CONFIG_SVH
`define PROG_CONFIG_SVH

`define BUF_DEPTH 1024 // bytes per buffer, four pages
`define BUF_AW 10
`define PAGE_SHIFT 8 // 256-byte pages

// returned by query_info
`define HDL_VERSION 8'h03
`define HW_VERSION 8'h01
`define HW_TYPE 8'h02

`endif

// File: link_pkg.sv
package link_pkg;

	typedef logic [7:0] byte_t;

	// host command codes, top bit set means a data payload follows
	typedef enum logic [7:0] {
		ccmd_read_buffer = 8'h01,
		ccmd_poll = 8'h02,
		ccmd_test_echo = 8'h03,
		ccmd_test_voltage = 8'h04,
		ccmd_query_info = 8'h06,
		ccmd_write_buffer = 8'h81
	} ccmd_e;

	typedef enum logic [7:0] {
		cresult_ack = 8'h06,
		cresult_busy = 8'h07,
		cresult_nack = 8'h15,
		cresult_async = 8'h16, // job accepted, poll for the outcome
		cresult_data = 8'h1a // followed by a data block
	} cresult_e;

	localparam byte_t sof_c = 8'h1b;

endpackage

// File: job_pkg.sv
`include "prog_config.svh"

package job_pkg;

	import link_pkg::*;

	typedef enum logic [1:0] {
		pcmd_echo,
		pcmd_voltage,
		pcmd_query
	} pcmd_e;

	typedef enum logic {
		presult_fail,
		presult_success
	} presult_e;

	typedef struct packed {
		pcmd_e cmd;
		logic [31:0] arg;
	} job_t;

	typedef struct packed {
		logic data; // send a read-buffer block after the code
		cresult_e code;
		logic [`BUF_AW-1:0] start;
		logic [`BUF_AW:0] size;
	} resp_t;

	typedef enum logic [3:0] {
		rail_vcc_gnd = 4'd1,
		rail_vcc_3v3,
		rail_vcc_5v,
		rail_vpp_gnd,
		rail_vpp_gnd_weak,
		rail_vpp_3v3,
		rail_vpp_3v7,
		rail_vpp_5v,
		rail_vpp_5v4,
		rail_vpp_12v25,
		rail_vpp_12v25_weak
	} rail_e;

	typedef logic [10:0] rails_t; // bit n-1 is rail n

endpackage

// File: toggle_channel.sv
`timescale 1ns/1ps

module toggle_channel #(
	parameter type payload_t = logic [7:0]
) (
	input logic clk12m,
	input logic sense_reset,
	input logic send,
	input payload_t payload_in,
	input logic done,
	output payload_t payload,
	output logic pending,
	output logic busy
);

	logic seq;
	logic ack;

	always_ff @(posedge clk12m) begin
		if (sense_reset) begin
			seq <= 1'b0;
			ack <= 1'b0;
		end else begin
			if (send)
				seq <= ~seq;
			if (done)
				ack <= seq; // receiver catches up
		end
	end

	always_ff @(posedge clk12m) begin
		if (send)
			payload <= payload_in;
	end

	assign pending = seq != ack; // receiver side
	assign busy = seq != ack; // sender side

	assert property (@(posedge clk12m) disable iff (sense_reset) send |-> !busy);
	assert property (@(posedge clk12m) disable iff (sense_reset) done |-> pending);

endmodule

// File: buffer_ram.sv
`timescale 1ns/1ps
`include "prog_config.svh"

module buffer_ram import link_pkg::*; (
	input logic clk12m,
	input logic we,
	input logic [`BUF_AW-1:0] waddr,
	input byte_t wdata,
	input logic [`BUF_AW-1:0] raddr,
	output byte_t rdata
);

	byte_t mem [`BUF_DEPTH];

	always_ff @(posedge clk12m) begin
		if (we)
			mem[waddr] <= wdata;
	end

	always_ff @(posedge clk12m) begin
		rdata <= mem[raddr]; // one cycle read latency
	end

endmodule

// File: cmd_decode.sv
`timescale 1ns/1ps
`include "prog_config.svh"

module cmd_decode import link_pkg::*, job_pkg::*; (
	input logic clk12m,
	input logic sense_reset,
	input byte_t rx_data,
	input logic rx_seq,
	output logic rx_ack,
	output logic wb_we,
	output logic [`BUF_AW-1:0] wb_addr,
	output byte_t wb_data,
	output logic job_send,
	output job_t job_out,
	input logic job_busy,
	input presult_e presult,
	output logic resp_send,
	output resp_t resp_out,
	input logic resp_busy
);

	typedef enum logic [2:0] {
		st_hunt,
		st_cmd,
		st_arg,
		st_data,
		st_dispatch
	} state_e;

	state_e state;
	byte_t cmd;
	logic [31:0] arg_q; // {arg3, arg2, arg1, arg0}
	logic [1:0] argi;
	logic [15:0] idx;
	logic [15:0] size;
	logic [`BUF_AW-1:0] page_start;
	logic rx_pend;
	logic rx_take;
	logic job_go;

	assign rx_pend = rx_seq != rx_ack;
	assign rx_take = rx_pend && state != st_dispatch;
	assign size = arg_q[31:16];
	assign page_start = `BUF_AW'(16'(arg_q[15:8]) << `PAGE_SHIFT);

	always_ff @(posedge clk12m) begin
		if (sense_reset) begin
			state <= st_hunt;
			rx_ack <= 1'b0;
			wb_we <= 1'b0;
		end else begin
			wb_we <= 1'b0;
			if (rx_take)
				rx_ack <= rx_seq;
			case (state)
			st_hunt:
				if (rx_pend && rx_data == sof_c)
					state <= st_cmd; // anything else is dropped
			st_cmd:
				if (rx_pend) begin
					cmd <= rx_data;
					argi <= 2'd0;
					state <= st_arg;
				end
			st_arg:
				if (rx_pend) begin
					arg_q <= {rx_data, arg_q[31:8]};
					argi <= argi + 2'd1;
					if (argi == 2'd3) begin
						idx <= 16'd0;
						if (cmd[7] && {rx_data, arg_q[31:24]} != 16'd0)
							state <= st_data;
						else
							state <= st_dispatch;
					end
				end
			st_data:
				if (rx_pend) begin
					wb_we <= cmd == ccmd_write_buffer; // other payload commands just drain
					wb_addr <= page_start + idx[`BUF_AW-1:0];
					wb_data <= rx_data;
					idx <= idx + 16'd1;
					if (idx + 16'd1 == size)
						state <= st_dispatch;
				end
			st_dispatch:
				if (!resp_busy)
					state <= st_hunt;
			default:
				state <= st_hunt;
			endcase
		end
	end

	always_comb begin
		resp_out.data = 1'b0;
		resp_out.code = cresult_nack;
		resp_out.start = page_start;
		resp_out.size = size[`BUF_AW:0];
		job_out.cmd = pcmd_echo;
		job_out.arg = arg_q;
		job_go = 1'b0;
		case (cmd)
		ccmd_write_buffer:
			resp_out.code = cresult_ack;
		ccmd_read_buffer: begin
			resp_out.data = 1'b1;
			resp_out.code = cresult_data;
		end
		ccmd_poll:
			if (job_busy)
				resp_out.code = cresult_busy;
			else
				resp_out.code = presult == presult_success ? cresult_ack : cresult_nack;
		ccmd_test_echo, ccmd_test_voltage, ccmd_query_info: begin
			if (cmd == ccmd_test_voltage)
				job_out.cmd = pcmd_voltage;
			else if (cmd == ccmd_query_info)
				job_out.cmd = pcmd_query;
			if (job_busy) begin
				resp_out.code = cresult_busy;
			end else begin
				resp_out.code = cresult_async;
				job_go = 1'b1;
			end
		end
		default:
			resp_out.code = cresult_nack;
		endcase
	end

	assign resp_send = state == st_dispatch && !resp_busy;
	assign job_send = resp_send && job_go;

endmodule

// File: job_execute.sv
`timescale 1ns/1ps
`include "prog_config.svh"

module job_execute import link_pkg::*, job_pkg::*; (
	input logic clk12m,
	input logic sense_reset,
	input job_t job,
	input logic job_pending,
	output logic job_done,
	output logic [`BUF_AW-1:0] wb_addr,
	input byte_t wb_rdata,
	output logic rb_we,
	output logic [`BUF_AW-1:0] rb_addr,
	output byte_t rb_data,
	output presult_e presult,
	output rails_t rails
);

	typedef enum logic {
		st_idle,
		st_run
	} state_e;

	state_e state;
	logic [`BUF_AW:0] cnt;
	logic [`BUF_AW:0] last;
	rail_e rail_sel;
	logic rail_ok;
	byte_t info_byte;

	assign rail_sel = rail_e'(job.arg[3:0]);
	assign rail_ok = job.arg[31:4] == 28'd0 &&
		rail_sel inside {[rail_vcc_gnd:rail_vpp_12v25_weak]};

	always_comb begin
		case (job.cmd)
		pcmd_voltage: last = '0;
		pcmd_query: last = (`BUF_AW+1)'(3);
		default: last = (`BUF_AW+1)'(`BUF_DEPTH + 1); // read latency plus write register
		endcase
	end

	always_comb begin
		case (cnt[1:0])
		2'd0: info_byte = 8'd4; // length
		2'd1: info_byte = `HDL_VERSION;
		2'd2: info_byte = `HW_VERSION;
		default: info_byte = `HW_TYPE;
		endcase
	end

	assign job_done = state == st_run && cnt == last;
	assign wb_addr = cnt[`BUF_AW-1:0];

	always_ff @(posedge clk12m) begin
		if (sense_reset) begin
			state <= st_idle;
			rails <= '0;
			presult <= presult_fail;
			rb_we <= 1'b0;
		end else begin
			rb_we <= 1'b0;
			case (state)
			st_idle:
				if (job_pending) begin
					state <= st_run;
					cnt <= '0;
				end
			st_run: begin
				cnt <= cnt + 1'b1;
				case (job.cmd)
				pcmd_voltage:
					rails <= rail_ok ? rails_t'(11'd1 << (rail_sel - 1)) : '0;
				pcmd_query: begin
					rb_we <= 1'b1;
					rb_addr <= cnt[`BUF_AW-1:0];
					rb_data <= info_byte;
				end
				default:
					if (cnt != '0 && cnt <= (`BUF_AW+1)'(`BUF_DEPTH)) begin
						rb_we <= 1'b1;
						rb_addr <= cnt[`BUF_AW-1:0] - `BUF_AW'(1); // data of previous address
						rb_data <= wb_rdata;
					end
				endcase
				if (job_done) begin
					state <= st_idle;
					presult <= presult_success;
				end
			end
			default:
				state <= st_idle;
			endcase
		end
	end

	// the job descriptor must hold still for the whole run
	assert property (@(posedge clk12m) disable iff (sense_reset) state == st_run |-> $stable(job));

endmodule

// File: result_send.sv
`timescale 1ns/1ps
`include "prog_config.svh"

module result_send import link_pkg::*, job_pkg::*; (
	input logic clk12m,
	input logic sense_reset,
	input resp_t resp,
	input logic resp_pending,
	output logic resp_done,
	output logic [`BUF_AW-1:0] rb_addr,
	input byte_t rb_rdata,
	output byte_t tx_data,
	output logic tx_seq,
	input logic tx_ack
);

	typedef enum logic [1:0] {
		st_idle,
		st_wait,
		st_data
	} state_e;

	state_e state;
	logic [`BUF_AW-1:0] addr;
	logic [`BUF_AW:0] remain;
	logic tx_free;
	logic more;

	assign tx_free = tx_seq == tx_ack;
	assign more = resp.data && remain != '0;
	assign resp_done = state == st_wait && tx_free && !more;
	assign rb_addr = addr; // read ahead, valid by the time the host acks

	always_ff @(posedge clk12m) begin
		if (sense_reset) begin
			state <= st_idle;
			tx_seq <= 1'b0;
		end else begin
			case (state)
			st_idle:
				if (resp_pending && tx_free) begin
					tx_data <= resp.code;
					tx_seq <= ~tx_seq;
					addr <= resp.start;
					remain <= resp.size;
					state <= st_wait;
				end
			st_wait:
				if (tx_free)
					state <= more ? st_data : st_idle;
			st_data: begin
				tx_data <= rb_rdata;
				tx_seq <= ~tx_seq;
				addr <= addr + 1'b1;
				remain <= remain - 1'b1;
				state <= st_wait;
			end
			default:
				state <= st_idle;
			endcase
		end
	end

endmodule

// File: prog_top.sv
`timescale 1ns/1ps
`include "prog_config.svh"

module prog_top import link_pkg::*, job_pkg::*; (
	input logic clk12m,
	input logic sense_reset,
	input byte_t rx_data,
	input logic rx_seq,
	output logic rx_ack,
	output byte_t tx_data,
	output logic tx_seq,
	input logic tx_ack,
	output rails_t rails
);

	logic job_send, job_pending, job_busy, job_done;
	job_t job_in, job_q;
	logic resp_send, resp_pending, resp_busy, resp_done;
	resp_t resp_in, resp_q;
	presult_e presult;

	logic wb_we;
	logic [`BUF_AW-1:0] wb_waddr, wb_raddr;
	byte_t wb_wdata, wb_rdata;
	logic rb_we;
	logic [`BUF_AW-1:0] rb_waddr, rb_raddr;
	byte_t rb_wdata, rb_rdata;

	cmd_decode u_cmd_decode (
		.clk12m, .sense_reset, .rx_data, .rx_seq, .rx_ack,
		.wb_we, .wb_addr(wb_waddr), .wb_data(wb_wdata),
		.job_send, .job_out(job_in), .job_busy, .presult,
		.resp_send, .resp_out(resp_in), .resp_busy
	);

	toggle_channel #(.payload_t(job_t)) u_job_chan (
		.clk12m, .sense_reset, .send(job_send), .payload_in(job_in), .done(job_done),
		.payload(job_q), .pending(job_pending), .busy(job_busy)
	);

	toggle_channel #(.payload_t(resp_t)) u_resp_chan (
		.clk12m, .sense_reset, .send(resp_send), .payload_in(resp_in), .done(resp_done),
		.payload(resp_q), .pending(resp_pending), .busy(resp_busy)
	);

	job_execute u_job_execute (
		.clk12m, .sense_reset, .job(job_q), .job_pending, .job_done,
		.wb_addr(wb_raddr), .wb_rdata,
		.rb_we, .rb_addr(rb_waddr), .rb_data(rb_wdata), .presult, .rails
	);

	result_send u_result_send (
		.clk12m, .sense_reset, .resp(resp_q), .resp_pending, .resp_done,
		.rb_addr(rb_raddr), .rb_rdata, .tx_data, .tx_seq, .tx_ack
	);

	buffer_ram u_wbuf (
		.clk12m, .we(wb_we), .waddr(wb_waddr), .wdata(wb_wdata),
		.raddr(wb_raddr), .rdata(wb_rdata)
	);

	buffer_ram u_rbuf (
		.clk12m, .we(rb_we), .waddr(rb_waddr), .wdata(rb_wdata),
		.raddr(rb_raddr), .rdata(rb_rdata)
	);

endmodule

// File: tb_prog.sv
`timescale 1ns/1ps
`include "prog_config.svh"

module tb_prog import link_pkg::*, job_pkg::*; ();

	// two echoes, two 256-byte transfers and about 30 frames come to roughly 6000 cycles
	localparam int timeout_cycles = 30000;
	localparam byte_t reply_ack = 8'h06;
	localparam byte_t reply_busy = 8'h07;
	localparam byte_t reply_nack = 8'h15;
	localparam byte_t reply_async = 8'h16;
	localparam byte_t reply_data = 8'h1a;

	logic clk12m = 1'b0;
	logic sense_reset;
	byte_t rx_data;
	logic rx_seq;
	logic rx_ack;
	byte_t tx_data;
	logic tx_seq;
	logic tx_ack;
	rails_t rails;

	logic [31:0] lfsr_state;
	int cycles;
	int checks;
	int value_errors;
	int protocol_errors;
	byte_t page_data [256];

	prog_top DUT (.*);

	always #4 clk12m = ~clk12m;

	// a reply byte may only follow once the host acked the previous one
	assert property (@(posedge clk12m) disable iff (sense_reset)
		$changed(tx_seq) |-> $past(tx_seq == tx_ack))
	else begin
		protocol_errors++;
		$display("tx_seq toggled while the previous reply byte was still unacked");
	end

	assert property (@(posedge clk12m) disable iff (sense_reset)
		$changed(rx_ack) |-> rx_ack == $past(rx_seq))
	else begin
		protocol_errors++;
		$display("rx_ack changed to a value that rx_seq did not hold");
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32, 22, 2, 1
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) checks++;
		else begin
			value_errors++;
			$display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic send_byte(input byte_t b);
		@(negedge clk12m);
		while (rx_seq !== rx_ack)
			@(negedge clk12m); // previous byte not taken yet
		@(posedge clk12m);
		rx_data <= b;
		rx_seq <= ~rx_seq;
	endtask

	task automatic send_frame(input byte_t cmd, input byte_t a0, a1, a2, a3);
		send_byte(8'h1b);
		send_byte(cmd);
		send_byte(a0);
		send_byte(a1); // page
		send_byte(a2); // size low
		send_byte(a3); // size high
	endtask

	task automatic recv_byte(output byte_t b);
		logic [31:0] delay;
		@(negedge clk12m);
		while (tx_seq === tx_ack)
			@(negedge clk12m);
		b = tx_data;
		take_bits(3, delay); // host back-pressure of 0 to 7 cycles
		repeat (delay) @(posedge clk12m);
		@(posedge clk12m);
		tx_ack <= tx_seq;
	endtask

	task automatic expect_reply(input byte_t exp);
		byte_t b;
		recv_byte(b);
		check_value("tx_data", b, exp);
	endtask

	task automatic poll_until_idle();
		byte_t b;
		b = reply_busy;
		while (b == reply_busy) begin
			send_frame(8'h02, 8'h00, 8'h00, 8'h00, 8'h00);
			recv_byte(b);
		end
		check_value("tx_data", b, reply_ack);
	endtask

	task automatic set_voltage(input byte_t n);
		logic [31:0] exp;
		exp = (n >= 1 && n <= 11) ? 32'd1 << (n - 1) : 32'd0;
		send_frame(8'h04, n, 8'h00, 8'h00, 8'h00);
		expect_reply(reply_async);
		poll_until_idle();
		check_value("rails", rails, exp);
	endtask

	initial begin
		cycles = 0;
		while (cycles < timeout_cycles) begin
			@(posedge clk12m);
			cycles++;
		end
		$display("run stopped after %0d cycles without reaching the end of the tests", cycles);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		logic [31:0] r;
		sense_reset = 1'b1;
		rx_data = '0;
		rx_seq = 1'b0;
		tx_ack = 1'b0;
		lfsr_state = 32'h069062f9;
		checks = 0;
		value_errors = 0;
		protocol_errors = 0;
		repeat (8) @(posedge clk12m);
		sense_reset <= 1'b0;
		@(negedge clk12m);
		check_value("rails", rails, 0);
		check_value("rx_ack", rx_ack, 0);
		check_value("tx_seq", tx_seq, 0);

		send_byte(8'h55); // noise ahead of the first frame
		send_byte(8'h00);
		send_byte(8'hea);
		send_frame(8'h42, 8'h00, 8'h00, 8'h00, 8'h00);
		expect_reply(reply_nack);

		for (int n = 1; n <= 11; n++)
			set_voltage(byte_t'(n));
		set_voltage(8'd0);
		set_voltage(8'd12);

		send_frame(8'h81, 8'h00, 8'h02, 8'h00, 8'h01); // page 2, 256 bytes
		for (int i = 0; i < 256; i++) begin
			take_bits(8, r);
			page_data[i] = r[7:0];
			send_byte(r[7:0]);
		end
		expect_reply(reply_ack);
		send_frame(8'h03, 8'h00, 8'h00, 8'h00, 8'h00);
		expect_reply(reply_async);
		poll_until_idle();
		send_frame(8'h01, 8'h00, 8'h02, 8'h00, 8'h01);
		expect_reply(reply_data);
		for (int i = 0; i < 256; i++)
			expect_reply(page_data[i]);

		send_frame(8'h06, 8'h00, 8'h00, 8'h00, 8'h00);
		expect_reply(reply_async);
		poll_until_idle();
		send_frame(8'h01, 8'h00, 8'h00, 8'h04, 8'h00);
		expect_reply(reply_data);
		expect_reply(8'h04);
		expect_reply(`HDL_VERSION);
		expect_reply(`HW_VERSION);
		expect_reply(`HW_TYPE);

		set_voltage(8'd3);
		send_frame(8'h03, 8'h00, 8'h00, 8'h00, 8'h00); // long echo keeps the engine busy
		expect_reply(reply_async);
		send_frame(8'h02, 8'h00, 8'h00, 8'h00, 8'h00);
		expect_reply(reply_busy);
		send_frame(8'h04, 8'h05, 8'h00, 8'h00, 8'h00);
		expect_reply(reply_busy);
		check_value("rails", rails, 32'h004);
		poll_until_idle();
		check_value("rails", rails, 32'h004);

		$display("checks %0d, value errors %0d, protocol errors %0d",
			checks, value_errors, protocol_errors);
		if (value_errors == 0 && protocol_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: src.f
+incdir+.
link_pkg.sv
job_pkg.sv
toggle_channel.sv
buffer_ram.sv
cmd_decode.sv
job_execute.sv
result_send.sv
prog_top.sv
tb_prog.sv

// File: Bender.yml
package:
  name: prom_host_cmd

sources:
  - include_dirs:
      - .
    files:
      - link_pkg.sv
      - job_pkg.sv
      - toggle_channel.sv
      - buffer_ram.sv
      - cmd_decode.sv
      - job_execute.sv
      - result_send.sv
      - prog_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_prog.sv
